/* vlog.f */
hw/spi_cmd_pkg.sv
hw/spi_cmd_decode.sv
hw/reg_write_ctrl.sv
hw/adc_burst_reader.sv
hw/tx_word_mux.sv
hw/spi_cmd_top.sv
bench/sck_gen.sv
bench/spi_cmd_tb.sv

/* bench/spi_cmd_tb.sv */
module spi_cmd_tb;
    import spi_cmd_pkg::*;

    localparam int N_FRAMES    = 300;
    // Worst frame is a 16-word burst at 6 idle cycles per word plus framing and settle
    localparam int FRAME_MAX   = 12 + 16 * 7;
    localparam int CYCLE_LIMIT = 20 + N_FRAMES * FRAME_MAX;
    // At most two pops per frame
    localparam int FIFO_FILL   = 2 * N_FRAMES + 4;

    logic                SCK;
    logic                NRST;
    logic                cs;
    logic                byte_rcvd;
    logic                word_rcvd;
    logic [BYTE_W-1:0]   cmd_byte;
    logic [BYTE_W-1:0]   data_byte;
    logic [ADC_W-1:0]    adc_data;
    logic [CFG_W-1:0]    cfg_data;
    logic [STATUS_W-1:0] status;
    logic                ensamp;
    logic [WORD_W-1:0]   tx_buff;
    logic                fifo_pop;
    logic [ADDR_W-1:0]   reg_addr;
    logic [BYTE_W-1:0]   reg_value;
    logic                wr_en;

    integer            seed;
    int                n_checks;
    int                n_errors;
    int                cycles;
    int                wr_cnt;
    int                pop_cnt;
    logic [ADDR_W-1:0] wr_addr_seen;
    logic [BYTE_W-1:0] wr_val_seen;
    logic [WORD_W-1:0] crc_model;
    logic [ADC_W-1:0]  fifo_q [$];

    sck_gen u_sck (.SCK(SCK));

    spi_cmd_top dut (
        .SCK(SCK), .NRST(NRST), .cs(cs), .byte_rcvd(byte_rcvd), .word_rcvd(word_rcvd),
        .cmd_byte(cmd_byte), .data_byte(data_byte), .adc_data(adc_data),
        .cfg_data(cfg_data), .status(status), .ensamp(ensamp), .tx_buff(tx_buff),
        .fifo_pop(fifo_pop), .reg_addr(reg_addr), .reg_value(reg_value), .wr_en(wr_en)
    );

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [ADC_W-1:0] rand_entry();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // CCITT step with poly 1021 and data MSB first
    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [15:0] w);
        logic fb;
        for (int b = 15; b >= 0; b--) begin
            fb  = crc[15] ^ w[b];
            crc = {crc[14:0], 1'b0};
            if (fb) begin
                crc = crc ^ 16'h1021;
            end
        end
        return crc;
    endfunction

    // Readback byte per address map
    function automatic logic [7:0] reg_byte_model(input logic [5:0] a);
        if (a <= 6'h23) begin
            return cfg_data[a*8 +: 8];
        end else if (a == 6'h24) begin
            return status[7:0];
        end else if (a == 6'h25) begin
            return {2'b00, status[13:8]};
        end
        return 8'h00;
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        n_checks++;
        assert (act === exp) else begin
            n_errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // FIFO head follows each observed pop
    always @(negedge SCK) begin
        if (NRST && wr_en) begin
            wr_cnt++;
            wr_addr_seen = reg_addr;
            wr_val_seen  = reg_value;
        end
        if (NRST && fifo_pop) begin
            pop_cnt++;
            void'(fifo_q.pop_front());
            adc_data = fifo_q[0];
        end
    end

    always @(posedge SCK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////
    // Frames
    ////////////////////

    // Between frames only and then settled through the synchronizers
    task automatic change_env();
        status = $random(seed);
        ensamp = $random(seed);
        for (int i = 0; i < CFG_BYTES; i++) begin
            cfg_data[i*8 +: 8] = $random(seed);
        end
        repeat (3) @(negedge SCK);
    endtask

    task automatic run_frame(input cmd_op_e op, input bit abort);
        logic [ADDR_W-1:0] addr;
        logic [ADC_W-1:0]  entry;
        logic [WORD_W-1:0] exp;
        logic [WORD_W-1:0] stat_w;
        bit                ignored;
        bit                wr_ok;
        int                nwords;
        int                wr_base;
        int                pop_base;
        addr = $random(seed);
        // Burst and CRC commands mostly with a zero address field
        if ((op == OP_RDDATA || op == OP_RDCRC) && ($random(seed) & 3) != 0) begin
            addr = '0;
        end
        ignored = (op == OP_RDDATA || op == OP_RDCRC) && addr != 0;
        nwords  = (op == OP_RDREG) ? 2 : 1;
        if (op == OP_RDDATA) begin
            nwords = 8 + $unsigned($random(seed)) % 9;
        end
        if (ignored) begin
            nwords = 1;
        end
        if (abort) begin
            nwords = 0;
        end
        wr_ok    = !abort && op == OP_WRREG && addr <= 6'h23 && (!ensamp || addr == 6'h23);
        stat_w   = {status, 2'b01};
        wr_base  = wr_cnt;
        pop_base = pop_cnt;
        @(negedge SCK) cs = 1'b0;
        @(negedge SCK);
        check_value("idle status", stat_w, tx_buff);
        byte_rcvd = 1'b1;
        cmd_byte  = {op, addr};
        @(negedge SCK) byte_rcvd = 1'b0;
        for (int k = 0; k < nwords; k++) begin
            repeat (2 + $unsigned($random(seed)) % 5) @(negedge SCK);
            exp = stat_w;
            if (!ignored && op == OP_RDREG && k == 1) begin
                exp = {8'hC0, reg_byte_model(addr)};
            end else if (!ignored && op == OP_RDCRC) begin
                exp = crc_model;
            end else if (!ignored && op == OP_RDDATA) begin
                entry = fifo_q[0];
                exp   = entry[(k % 8)*16 +: 16];
                // Fresh CRC per burst
                if (k == 0) begin
                    crc_model = 16'hFFFF;
                end
                crc_model = crc_step(crc_model, exp);
            end
            check_value(ignored ? "ignored cmd" : op.name(), exp, tx_buff);
            word_rcvd = 1'b1;
            data_byte = $random(seed);
            @(negedge SCK) word_rcvd = 1'b0;
        end
        repeat (3) @(negedge SCK);
        cs = 1'b1;
        repeat (2) @(negedge SCK);
        check_value("wr_en count", wr_ok, wr_cnt - wr_base);
        if (wr_ok && wr_cnt > wr_base) begin
            check_value("write address", addr, wr_addr_seen);
            check_value("write data", data_byte, wr_val_seen);
        end
        check_value("pop count", (op == OP_RDDATA && !ignored) ? nwords / 8 : 0,
                    pop_cnt - pop_base);
    endtask

    initial begin
        seed      = 32'he546;
        NRST      = 1'b0;
        cs        = 1'b1;
        byte_rcvd = 1'b0;
        word_rcvd = 1'b0;
        cmd_byte  = '0;
        data_byte = '0;
        status    = '0;
        ensamp    = 1'b0;
        cfg_data  = '0;
        n_checks  = 0;
        n_errors  = 0;
        cycles    = 0;
        wr_cnt    = 0;
        pop_cnt   = 0;
        crc_model = 16'hFFFF;
        repeat (FIFO_FILL) fifo_q.push_back(rand_entry());
        adc_data = fifo_q[0];
        repeat (10) @(negedge SCK);
        NRST = 1'b1;
        change_env();
        for (int f = 0; f < N_FRAMES; f++) begin
            if (f % 4 == 3) begin
                change_env();
            end
            // About one frame in twelve is cut short by deselect
            run_frame(cmd_op_e'($random(seed)), ($unsigned($random(seed)) % 12) == 0);
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* bench/sck_gen.sv */
module sck_gen (
    output logic SCK
);
    // Half of the 4-unit period
    localparam int HALF = 2;

    initial begin
        SCK = 1'b0;
    end

    always #HALF SCK = ~SCK;

endmodule

/* hw/spi_cmd_top.sv */
module spi_cmd_top (
    input  logic                                SCK,
    input  logic                                NRST,
    input  logic                                cs,
    input  logic                                byte_rcvd,
    input  logic                                word_rcvd,
    input  logic [spi_cmd_pkg::BYTE_W-1:0]      cmd_byte,
    input  logic [spi_cmd_pkg::BYTE_W-1:0]      data_byte,
    input  logic [spi_cmd_pkg::ADC_W-1:0]       adc_data,
    input  logic [spi_cmd_pkg::CFG_W-1:0]       cfg_data,
    input  logic [spi_cmd_pkg::STATUS_W-1:0]    status,
    input  logic                                ensamp,
    output logic [spi_cmd_pkg::WORD_W-1:0]      tx_buff,
    output logic                                fifo_pop,
    output logic [spi_cmd_pkg::ADDR_W-1:0]      reg_addr,
    output logic [spi_cmd_pkg::BYTE_W-1:0]      reg_value,
    output logic                                wr_en
);
    import spi_cmd_pkg::*;

    cmd_state_e                         state;
    logic                               rd_second;
    logic [$clog2(BURST_WORDS)-1:0]     word_idx;
    logic [WORD_W-1:0]                  crc_value;

    // Command FSM
    spi_cmd_decode u_decode (
        .SCK(SCK), .NRST(NRST), .cs(cs),
        .byte_rcvd(byte_rcvd), .word_rcvd(word_rcvd), .cmd_byte(cmd_byte),
        .state(state), .reg_addr(reg_addr), .rd_second(rd_second)
    );

    // Config register writes
    reg_write_ctrl u_write (
        .SCK(SCK), .NRST(NRST), .word_rcvd(word_rcvd), .ensamp(ensamp),
        .state(state), .reg_addr(reg_addr), .data_byte(data_byte),
        .reg_value(reg_value), .wr_en(wr_en)
    );

    // FIFO readout and CRC
    adc_burst_reader u_burst (
        .SCK(SCK), .NRST(NRST), .word_rcvd(word_rcvd), .state(state),
        .adc_data(adc_data), .word_idx(word_idx), .crc_value(crc_value),
        .fifo_pop(fifo_pop)
    );

    ////////////////////
    // Outgoing word
    ////////////////////

    tx_word_mux u_mux (
        .SCK(SCK), .NRST(NRST), .state(state), .rd_second(rd_second),
        .reg_addr(reg_addr), .word_idx(word_idx), .crc_value(crc_value),
        .cfg_data(cfg_data), .status(status), .adc_data(adc_data),
        .tx_buff(tx_buff)
    );

endmodule

/* hw/tx_word_mux.sv */
module tx_word_mux (
    input  logic                                            SCK,
    input  logic                                            NRST,
    input  spi_cmd_pkg::cmd_state_e                         state,
    input  logic                                            rd_second,
    input  logic [spi_cmd_pkg::ADDR_W-1:0]                  reg_addr,
    input  logic [$clog2(spi_cmd_pkg::BURST_WORDS)-1:0]     word_idx,
    input  logic [spi_cmd_pkg::WORD_W-1:0]                  crc_value,
    input  logic [spi_cmd_pkg::CFG_W-1:0]                   cfg_data,
    input  logic [spi_cmd_pkg::STATUS_W-1:0]                status,
    input  logic [spi_cmd_pkg::ADC_W-1:0]                   adc_data,
    output logic [spi_cmd_pkg::WORD_W-1:0]                  tx_buff
);
    import spi_cmd_pkg::*;

    logic [STATUS_W-1:0] status_meta;
    logic [STATUS_W-1:0] status_q;
    logic [WORD_W-1:0]   status_word;
    logic [BYTE_W-1:0]   reg_byte;

    ////////////////////
    // Status sync
    ////////////////////

    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            status_meta <= '0;
            status_q    <= '0;
        end else begin
            status_meta <= status;
            status_q    <= status_meta;
        end
    end

    // Status with response tag in the low bits
    assign status_word = {status_q, RESP_STATUS};

    // Register read data by address
    always_comb begin
        reg_byte = '0;
        if (reg_addr <= ADDR_CFG_LAST) begin
            reg_byte = cfg_data[reg_addr*BYTE_W +: BYTE_W];
        end else if (reg_addr == ADDR_STATUS_LO) begin
            reg_byte = status_q[BYTE_W-1:0];
        end else if (reg_addr == ADDR_STATUS_HI) begin
            // Upper status bits, zero-extended
            reg_byte = {{(2*BYTE_W-STATUS_W){1'b0}}, status_q[STATUS_W-1:BYTE_W]};
        end
    end

    ////////////////////
    // Response word
    ////////////////////

    always_comb begin
        case (state)
            ST_READ_REG:  tx_buff = rd_second ? {RESP_REGDATA, reg_byte} : status_word;
            ST_READ_DATA: tx_buff = adc_data[word_idx*WORD_W +: WORD_W];
            ST_READ_CRC:  tx_buff = crc_value;
            // Idle and write acknowledge
            default:      tx_buff = status_word;
        endcase
    end

endmodule

/* hw/adc_burst_reader.sv */
module adc_burst_reader (
    input  logic                                            SCK,
    input  logic                                            NRST,
    input  logic                                            word_rcvd,
    input  spi_cmd_pkg::cmd_state_e                         state,
    input  logic [spi_cmd_pkg::ADC_W-1:0]                   adc_data,
    output logic [$clog2(spi_cmd_pkg::BURST_WORDS)-1:0]     word_idx,
    output logic [spi_cmd_pkg::WORD_W-1:0]                  crc_value,
    output logic                                            fifo_pop
);
    import spi_cmd_pkg::*;

    logic              in_burst;
    logic              burst_word;
    logic              last_word;
    logic              crc_running;
    logic [WORD_W-1:0] cur_word;
    logic [WORD_W-1:0] crc_base;

    assign in_burst   = (state == ST_READ_DATA);
    assign burst_word = in_burst && word_rcvd;
    assign last_word  = (int'(word_idx) == BURST_WORDS - 1);

    // Word on the wire, lowest slice first
    assign cur_word = adc_data[word_idx*WORD_W +: WORD_W];

    ////////////////////
    // Word counter
    ////////////////////

    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            word_idx <= '0;
        end else if (!in_burst) begin
            word_idx <= '0;
        end else if (word_rcvd) begin
            // Wraps into the next FIFO entry
            word_idx <= word_idx + 1'b1;
        end
    end

    // Pop once the eighth word has gone out
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            fifo_pop <= 1'b0;
        end else begin
            fifo_pop <= burst_word && last_word;
        end
    end

    ////////////////////
    // Burst CRC
    ////////////////////

    // Fresh seed on the first word of a burst
    assign crc_base = crc_running ? crc_value : CRC_INIT;

    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            crc_running <= 1'b0;
            crc_value   <= CRC_INIT;
        end else begin
            if (burst_word) begin
                crc_value   <= crc16_next(crc_base, cur_word);
                crc_running <= 1'b1;
            end else if (!in_burst) begin
                // Keep the result for a later readback
                crc_running <= 1'b0;
            end
        end
    end

    a_pop_pulse: assert property (@(posedge SCK) disable iff (!NRST)
        fifo_pop |=> !fifo_pop);

endmodule

/* hw/reg_write_ctrl.sv */
module reg_write_ctrl (
    input  logic                                SCK,
    input  logic                                NRST,
    input  logic                                word_rcvd,
    input  logic                                ensamp,
    input  spi_cmd_pkg::cmd_state_e             state,
    input  logic [spi_cmd_pkg::ADDR_W-1:0]      reg_addr,
    input  logic [spi_cmd_pkg::BYTE_W-1:0]      data_byte,
    output logic [spi_cmd_pkg::BYTE_W-1:0]      reg_value,
    output logic                                wr_en
);
    import spi_cmd_pkg::*;

    logic [1:0] ensamp_sync;
    logic       wr_allowed;
    logic       wr_accept;

    ////////////////////
    // Sampling enable sync
    ////////////////////

    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            ensamp_sync <= 2'b00;
        end else begin
            ensamp_sync <= {ensamp_sync[0], ensamp};
        end
    end

    // Config range only; locked while sampling except sample control
    assign wr_allowed = (reg_addr <= ADDR_CFG_LAST) &&
                        (!ensamp_sync[1] || (reg_addr == ADDR_SAMPLE_CTRL));
    assign wr_accept  = (state == ST_WRITE_REG) && word_rcvd && wr_allowed;

    // Single-cycle strobe after the data word
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= wr_accept;
        end
    end

    // Write data held until the next accepted write
    always_ff @(posedge SCK) begin
        if (wr_accept) begin
            reg_value <= data_byte;
        end
    end

    a_wr_en_pulse: assert property (@(posedge SCK) disable iff (!NRST)
        wr_en |=> !wr_en);

    a_wr_en_range: assert property (@(posedge SCK) disable iff (!NRST)
        wr_en |-> (reg_addr <= ADDR_CFG_LAST));

endmodule

/* hw/spi_cmd_decode.sv */
module spi_cmd_decode (
    input  logic                                SCK,
    input  logic                                NRST,
    input  logic                                cs,
    input  logic                                byte_rcvd,
    input  logic                                word_rcvd,
    input  logic [spi_cmd_pkg::BYTE_W-1:0]      cmd_byte,
    output spi_cmd_pkg::cmd_state_e             state,
    output logic [spi_cmd_pkg::ADDR_W-1:0]      reg_addr,
    output logic                                rd_second
);
    import spi_cmd_pkg::*;

    cmd_state_e nstate;
    cmd_op_e    op;

    // Opcode field of the incoming command
    assign op = cmd_op_e'(cmd_byte[BYTE_W-1:BYTE_W-2]);

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        nstate = state;
        case (state)
            ST_IDLE: begin
                if (byte_rcvd) begin
                    case (op)
                        OP_RDREG:  nstate = ST_READ_REG;
                        OP_WRREG:  nstate = ST_WRITE_REG;
                        // Burst and CRC need a zero address field
                        OP_RDDATA: if (cmd_byte[ADDR_W-1:0] == '0) nstate = ST_READ_DATA;
                        OP_RDCRC:  if (cmd_byte[ADDR_W-1:0] == '0) nstate = ST_READ_CRC;
                        default:   nstate = ST_IDLE;
                    endcase
                end
            end
            // Status word first, register data second
            ST_READ_REG:  if (word_rcvd && rd_second) nstate = ST_IDLE;
            ST_WRITE_REG: if (word_rcvd) nstate = ST_IDLE;
            // Burst runs until deselect
            ST_READ_DATA: nstate = ST_READ_DATA;
            ST_READ_CRC:  if (word_rcvd) nstate = ST_IDLE;
            default:      nstate = ST_IDLE;
        endcase
    end

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            state <= ST_IDLE;
        end else if (cs) begin
            // Deselect aborts any command
            state <= ST_IDLE;
        end else begin
            state <= nstate;
        end
    end

    // Address capture and register-read word count
    always_ff @(posedge SCK or negedge NRST) begin
        if (!NRST) begin
            reg_addr  <= '0;
            rd_second <= 1'b0;
        end else begin
            if (byte_rcvd && (state == ST_IDLE)) begin
                reg_addr <= cmd_byte[ADDR_W-1:0];
            end
            if ((state == ST_READ_REG) && word_rcvd) begin
                rd_second <= 1'b1;
            end else if (state != ST_READ_REG) begin
                rd_second <= 1'b0;
            end
        end
    end

    a_state_legal: assert property (@(posedge SCK) disable iff (!NRST)
        state inside {ST_IDLE, ST_READ_REG, ST_WRITE_REG, ST_READ_DATA, ST_READ_CRC});

endmodule

/* hw/spi_cmd_pkg.sv */
package spi_cmd_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int WORD_W      = 16;
    localparam int BYTE_W      = 8;
    localparam int ADDR_W      = 6;
    localparam int STATUS_W    = 14;
    // One FIFO entry holds eight SPI words
    localparam int BURST_WORDS = 8;
    localparam int ADC_W       = BURST_WORDS * WORD_W;
    localparam int CFG_BYTES   = 36;
    localparam int CFG_W       = CFG_BYTES * BYTE_W;

    ////////////////////
    // Address map
    ////////////////////

    localparam logic [ADDR_W-1:0] ADDR_CFG_LAST    = 6'h23;
    // Sampling control stays writable while sampling runs
    localparam logic [ADDR_W-1:0] ADDR_SAMPLE_CTRL = 6'h23;
    localparam logic [ADDR_W-1:0] ADDR_STATUS_LO   = 6'h24;
    localparam logic [ADDR_W-1:0] ADDR_STATUS_HI   = 6'h25;

    ////////////////////
    // Response constants
    ////////////////////

    localparam logic [BYTE_W-1:0] RESP_REGDATA = 8'hC0;
    localparam logic [1:0]        RESP_STATUS  = 2'b01;
    localparam logic [WORD_W-1:0] CRC_INIT     = 16'hFFFF;
    // CCITT polynomial x^16 + x^12 + x^5 + 1
    localparam logic [WORD_W-1:0] CRC_POLY     = 16'h1021;

    // Opcode in cmd_byte[7:6]
    typedef enum logic [1:0] {
        OP_RDREG  = 2'd0,
        OP_RDCRC  = 2'd1,
        OP_WRREG  = 2'd2,
        OP_RDDATA = 2'd3
    } cmd_op_e;

    // One-hot command states
    typedef enum logic [4:0] {
        ST_IDLE       = 5'b00001,
        ST_READ_REG   = 5'b00010,
        ST_WRITE_REG  = 5'b00100,
        ST_READ_DATA  = 5'b01000,
        ST_READ_CRC   = 5'b10000
    } cmd_state_e;

    // One word step of CRC-16-CCITT, MSB first
    function automatic logic [WORD_W-1:0] crc16_next(
        input logic [WORD_W-1:0] crc_in,
        input logic [WORD_W-1:0] data_in
    );
        logic [WORD_W-1:0] crc;
        crc = crc_in;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (crc[WORD_W-1] ^ data_in[i]) begin
                crc = {crc[WORD_W-2:0], 1'b0} ^ CRC_POLY;
            end else begin
                crc = {crc[WORD_W-2:0], 1'b0};
            end
        end
        return crc;
    endfunction

endpackage
